/* rtl/memPeriphPkg.sv */
package memPeriphPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int ramWords  = 256;

    typedef logic [7:0]           wordIndexT;
    typedef logic [dataWidth-1:0] busWordT;
    typedef logic [6:0]           segCodeT;
    typedef logic [17:0]          tubeT;
    typedef logic [7:0]           ledT;
    typedef logic [7:0]           switchT;

    // RAM and digit table regions are both 1 KB wide
    localparam int regionBits = 10;

    localparam logic [addrWidth-1:0] ramBase          = 32'h0000_0000;
    localparam logic [addrWidth-1:0] digitBase        = 32'h0000_0400;
    localparam logic [addrWidth-1:0] timerReloadAddr  = 32'h4000_0000;
    localparam logic [addrWidth-1:0] timerCountAddr   = 32'h4000_0004;
    localparam logic [addrWidth-1:0] timerControlAddr = 32'h4000_0008;
    localparam logic [addrWidth-1:0] ledAddr          = 32'h4000_000C;
    localparam logic [addrWidth-1:0] switchAddr       = 32'h4000_0010;
    localparam logic [addrWidth-1:0] tubeAddr         = 32'h4000_0014;

    // Word offsets seen by the targets on regAddr
    localparam wordIndexT ledOffset          = wordIndexT'((ledAddr - ledAddr) >> 2);
    localparam wordIndexT switchOffset       = wordIndexT'((switchAddr - ledAddr) >> 2);
    localparam wordIndexT tubeOffset         = wordIndexT'((tubeAddr - ledAddr) >> 2);
    localparam wordIndexT timerReloadOffset  = wordIndexT'((timerReloadAddr - timerReloadAddr) >> 2);
    localparam wordIndexT timerCountOffset   = wordIndexT'((timerCountAddr - timerReloadAddr) >> 2);
    localparam wordIndexT timerControlOffset = wordIndexT'((timerControlAddr - timerReloadAddr) >> 2);

    localparam tubeT tubeResetValue = '1;

    // Segment patterns, bit 0 is segment a
    localparam segCodeT segTable [0:9] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
        7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111
    };

    localparam int timerEnableBit    = 0;
    localparam int timerIrqEnableBit = 1;
    localparam int timerFlagBit      = 2;

endpackage

/* rtl/periphBusIf.sv */
`timescale 1ns/1ns

interface periphBusIf;

    memPeriphPkg::wordIndexT regAddr;
    memPeriphPkg::busWordT   writeData;
    logic                    writeStrobe;
    memPeriphPkg::busWordT   readData;

    modport ctrl (
        output regAddr,
        output writeData,
        output writeStrobe,
        input  readData
    );

    // Targets return registered read data for the ack cycle
    modport target (
        input  regAddr,
        input  writeData,
        input  writeStrobe,
        output readData
    );

endinterface

/* rtl/digitDecoder.sv */
`timescale 1ns/1ns

module digitDecoder (
    input  memPeriphPkg::wordIndexT       digitIndex,
    output memPeriphPkg::segCodeT [2:0]   segCodes
);

    memPeriphPkg::wordIndexT rem;
    logic [3:0]              hundreds;
    logic [3:0]              tens;

    always_comb begin
        rem      = digitIndex;
        hundreds = 4'd0;
        tens     = 4'd0;
        // 255 holds at most two hundreds
        for (int i = 0; i < 2; i++) begin
            if (rem >= 8'd100) begin
                rem      = rem - 8'd100;
                hundreds = hundreds + 4'd1;
            end
        end
        for (int i = 0; i < 9; i++) begin
            if (rem >= 8'd10) begin
                rem  = rem - 8'd10;
                tens = tens + 4'd1;
            end
        end
    end

    // Hundreds in the top code, ones in the bottom
    assign segCodes[2] = memPeriphPkg::segTable[hundreds];
    assign segCodes[1] = memPeriphPkg::segTable[tens];
    assign segCodes[0] = memPeriphPkg::segTable[rem[3:0]];

endmodule

/* rtl/dataRam.sv */
`timescale 1ns/1ns

module dataRam (
    input  logic     Uart_send_trigger,
    input  logic     clk,
    periphBusIf.target bus
);

    memPeriphPkg::busWordT mem [memPeriphPkg::ramWords];

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < memPeriphPkg::ramWords; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.writeStrobe) begin
            mem[bus.regAddr] <= bus.writeData;
        end
    end

    // Read data is ready in the ack cycle
    always_ff @(posedge Uart_send_trigger) begin
        bus.readData <= mem[bus.regAddr];
    end

endmodule

/* rtl/ioPorts.sv */
`timescale 1ns/1ns

module ioPorts (
    input  logic                 Uart_send_trigger,
    input  logic                 clk,
    periphBusIf.target           bus,
    input  memPeriphPkg::switchT switch,
    output memPeriphPkg::ledT    led,
    output memPeriphPkg::tubeT   tube
);

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            led  <= '0;
            tube <= memPeriphPkg::tubeResetValue;
        end else if (bus.writeStrobe) begin
            // Switches are input only
            if (bus.regAddr == memPeriphPkg::ledOffset) begin
                led <= bus.writeData[7:0];
            end
            if (bus.regAddr == memPeriphPkg::tubeOffset) begin
                tube <= bus.writeData[17:0];
            end
        end
    end

    always_ff @(posedge Uart_send_trigger) begin
        if (bus.regAddr == memPeriphPkg::ledOffset) begin
            bus.readData <= memPeriphPkg::busWordT'(led);
        end else if (bus.regAddr == memPeriphPkg::switchOffset) begin
            bus.readData <= memPeriphPkg::busWordT'(switch);
        end else if (bus.regAddr == memPeriphPkg::tubeOffset) begin
            bus.readData <= memPeriphPkg::busWordT'(tube);
        end else begin
            bus.readData <= '0;
        end
    end

endmodule

/* rtl/intervalTimer.sv */
`timescale 1ns/1ns

module intervalTimer (
    input  logic       Uart_send_trigger,
    input  logic       clk,
    periphBusIf.target bus,
    output logic       timerExpired
);

    memPeriphPkg::busWordT reload;
    memPeriphPkg::busWordT count;
    memPeriphPkg::busWordT controlWord;
    logic                  enable;
    logic                  irqEnable;
    logic                  flag;
    logic                  ctrlWrite;

    assign ctrlWrite = bus.writeStrobe && (bus.regAddr == memPeriphPkg::timerControlOffset);

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            reload       <= '0;
            count        <= '0;
            enable       <= 1'b0;
            irqEnable    <= 1'b0;
            flag         <= 1'b0;
            timerExpired <= 1'b0;
        end else begin
            timerExpired <= flag && irqEnable;
            if (bus.writeStrobe && bus.regAddr == memPeriphPkg::timerReloadOffset) begin
                reload <= bus.writeData;
            end
            // A count write overrides the running count
            if (bus.writeStrobe && bus.regAddr == memPeriphPkg::timerCountOffset) begin
                count <= bus.writeData;
            end else if (enable) begin
                count <= (count == '1) ? reload : count + 1'b1;
            end
            if (ctrlWrite) begin
                enable    <= bus.writeData[memPeriphPkg::timerEnableBit];
                irqEnable <= bus.writeData[memPeriphPkg::timerIrqEnableBit];
                flag      <= 1'b0;
            end else if (enable && count == '1) begin
                flag <= 1'b1;
            end
        end
    end

    always_comb begin
        controlWord                                  = '0;
        controlWord[memPeriphPkg::timerEnableBit]    = enable;
        controlWord[memPeriphPkg::timerIrqEnableBit] = irqEnable;
        controlWord[memPeriphPkg::timerFlagBit]      = flag;
    end

    always_ff @(posedge Uart_send_trigger) begin
        case (bus.regAddr)
            memPeriphPkg::timerReloadOffset:  bus.readData <= reload;
            memPeriphPkg::timerCountOffset:   bus.readData <= count;
            memPeriphPkg::timerControlOffset: bus.readData <= controlWord;
            default:                          bus.readData <= '0;
        endcase
    end

endmodule

/* rtl/busController.sv */
`timescale 1ns/1ns

module busController (
    input  logic                                   Uart_send_trigger,
    input  logic                                   clk,
    input  logic                                   cyc,
    input  logic                                   stb,
    input  logic                                   we,
    input  logic [memPeriphPkg::addrWidth-1:0]     adr,
    input  memPeriphPkg::busWordT                  datWrite,
    output memPeriphPkg::busWordT                  datRead,
    output logic                                   ack,
    output memPeriphPkg::wordIndexT                digitIndex,
    input  memPeriphPkg::segCodeT [2:0]            segCodes,
    periphBusIf.ctrl                               ramBus,
    periphBusIf.ctrl                               ioBus,
    periphBusIf.ctrl                               timerBus
);

    logic                  accept;
    logic                  hitRam;
    logic                  hitDigit;
    logic                  hitIo;
    logic                  hitTimer;
    logic                  selRam;
    logic                  selDigit;
    logic                  selIo;
    logic                  selTimer;
    memPeriphPkg::busWordT digitData;

    // A request is taken only while no ack is pending
    assign accept = cyc && stb && !ack;

    assign hitRam   = (adr >> memPeriphPkg::regionBits) ==
                      (memPeriphPkg::ramBase >> memPeriphPkg::regionBits);
    assign hitDigit = (adr >> memPeriphPkg::regionBits) ==
                      (memPeriphPkg::digitBase >> memPeriphPkg::regionBits);
    assign hitIo    = (adr == memPeriphPkg::ledAddr) || (adr == memPeriphPkg::switchAddr) ||
                      (adr == memPeriphPkg::tubeAddr);
    assign hitTimer = (adr == memPeriphPkg::timerReloadAddr) ||
                      (adr == memPeriphPkg::timerCountAddr) ||
                      (adr == memPeriphPkg::timerControlAddr);

    assign digitIndex = adr[9:2];

    assign ramBus.regAddr   = adr[9:2];
    assign ioBus.regAddr    = memPeriphPkg::wordIndexT'((adr - memPeriphPkg::ledAddr) >> 2);
    assign timerBus.regAddr = memPeriphPkg::wordIndexT'((adr - memPeriphPkg::timerReloadAddr) >> 2);

    assign ramBus.writeData   = datWrite;
    assign ioBus.writeData    = datWrite;
    assign timerBus.writeData = datWrite;

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            ack                  <= 1'b0;
            ramBus.writeStrobe   <= 1'b0;
            ioBus.writeStrobe    <= 1'b0;
            timerBus.writeStrobe <= 1'b0;
            selRam               <= 1'b0;
            selDigit             <= 1'b0;
            selIo                <= 1'b0;
            selTimer             <= 1'b0;
        end else begin
            ack                  <= accept;
            ramBus.writeStrobe   <= accept && we && hitRam;
            ioBus.writeStrobe    <= accept && we && hitIo;
            timerBus.writeStrobe <= accept && we && hitTimer;
            if (accept) begin
                selRam   <= hitRam;
                selDigit <= hitDigit;
                selIo    <= hitIo;
                selTimer <= hitTimer;
            end
        end
    end

    always_ff @(posedge Uart_send_trigger) begin
        if (accept) begin
            digitData <= memPeriphPkg::busWordT'(segCodes);
        end
    end

    // Unmapped addresses fall through to zero
    always_comb begin
        if (selRam) begin
            datRead = ramBus.readData;
        end else if (selDigit) begin
            datRead = digitData;
        end else if (selIo) begin
            datRead = ioBus.readData;
        end else if (selTimer) begin
            datRead = timerBus.readData;
        end else begin
            datRead = '0;
        end
    end

endmodule

/* rtl/dataMemory.sv */
`timescale 1ns/1ns

module dataMemory (
    input  logic                               Uart_send_trigger,
    input  logic                               clk,
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [memPeriphPkg::addrWidth-1:0] adr,
    input  memPeriphPkg::busWordT              datWrite,
    output memPeriphPkg::busWordT              datRead,
    output logic                               ack,
    input  memPeriphPkg::switchT               switch,
    output memPeriphPkg::ledT                  led,
    output memPeriphPkg::tubeT                 tube,
    output logic                               timerExpired
);

    memPeriphPkg::wordIndexT     digitIndex;
    memPeriphPkg::segCodeT [2:0] segCodes;

    periphBusIf ramBus ();
    periphBusIf ioBus ();
    periphBusIf timerBus ();

    busController busController (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .cyc               (cyc),
        .stb               (stb),
        .we                (we),
        .adr               (adr),
        .datWrite          (datWrite),
        .datRead           (datRead),
        .ack               (ack),
        .digitIndex        (digitIndex),
        .segCodes          (segCodes),
        .ramBus            (ramBus.ctrl),
        .ioBus             (ioBus.ctrl),
        .timerBus          (timerBus.ctrl)
    );

    dataRam dataRam (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .bus               (ramBus.target)
    );

    // The digit table is computed rather than stored
    digitDecoder digitDecoder (
        .digitIndex (digitIndex),
        .segCodes   (segCodes)
    );

    ioPorts ioPorts (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .bus               (ioBus.target),
        .switch            (switch),
        .led               (led),
        .tube              (tube)
    );

    intervalTimer intervalTimer (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .bus               (timerBus.target),
        .timerExpired      (timerExpired)
    );

endmodule

/* verif/dataMemoryAssert.sv */
`timescale 1ns/1ns

module dataMemoryAssert (
    input logic Uart_send_trigger,
    input logic clk,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic ramStrobe,
    input logic ioStrobe,
    input logic timerStrobe
);

    int violations = 0;

    // ack answers a request seen on the previous edge
    ackAfterRequest: assert property (@(posedge Uart_send_trigger) disable iff (clk)
        $rose(ack) |-> $past(cyc && stb))
        else begin
            violations++;
            $error("ack rose without a request");
        end

    ackSingleCycle: assert property (@(posedge Uart_send_trigger) disable iff (clk)
        ack |=> !ack)
        else begin
            violations++;
            $error("ack held high for two cycles");
        end

    // Only one target may take a write at a time
    oneStrobe: assert property (@(posedge Uart_send_trigger) disable iff (clk)
        $onehot0({ramStrobe, ioStrobe, timerStrobe}))
        else begin
            violations++;
            $error("more than one write strobe high");
        end

endmodule

bind busController dataMemoryAssert busCheck (
    .Uart_send_trigger (Uart_send_trigger),
    .clk               (clk),
    .cyc               (cyc),
    .stb               (stb),
    .ack               (ack),
    .ramStrobe         (ramBus.writeStrobe),
    .ioStrobe          (ioBus.writeStrobe),
    .timerStrobe       (timerBus.writeStrobe)
);

/* verif/dataMemoryTb.sv */
`timescale 1ns/1ns

module dataMemoryTb;

    localparam int ackLimit  = 10;
    localparam int pollLimit = 40;

    logic                               Uart_send_trigger;
    logic                               clk;
    logic                               cyc;
    logic                               stb;
    logic                               we;
    logic [memPeriphPkg::addrWidth-1:0] adr;
    memPeriphPkg::busWordT              datWrite;
    memPeriphPkg::busWordT              datRead;
    logic                               ack;
    memPeriphPkg::switchT               switch;
    memPeriphPkg::ledT                  led;
    memPeriphPkg::tubeT                 tube;
    logic                               timerExpired;

    integer                  seed;
    int                      errorCount;
    int                      checkCount;
    int                      errorsAtStart;
    memPeriphPkg::busWordT   ramModel [memPeriphPkg::ramWords];
    memPeriphPkg::ledT       ledModel;
    memPeriphPkg::tubeT      tubeModel;

    dataMemory uut (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .cyc               (cyc),
        .stb               (stb),
        .we                (we),
        .adr               (adr),
        .datWrite          (datWrite),
        .datRead           (datRead),
        .ack               (ack),
        .switch            (switch),
        .led               (led),
        .tube              (tube),
        .timerExpired      (timerExpired)
    );

    initial begin
        Uart_send_trigger = 1'b0;
        forever #50 Uart_send_trigger = ~Uart_send_trigger;
    end

    task automatic abortRun(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Test failed");
        $finish;
    endtask

    task automatic compareWord(input string name, input memPeriphPkg::busWordT expected,
                               input memPeriphPkg::busWordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareTube(input string name, input memPeriphPkg::tubeT expected,
                               input memPeriphPkg::tubeT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareLed(input string name, input memPeriphPkg::ledT expected,
                              input memPeriphPkg::ledT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Waits on falling edges so ack and datRead are settled
    task automatic waitAck(input logic [31:0] addr);
        int waited;
        waited = 0;
        @(negedge Uart_send_trigger);
        while (!ack && waited < ackLimit) begin
            @(negedge Uart_send_trigger);
            waited++;
        end
        if (!ack) begin
            abortRun($sformatf("No ack for the transfer at address %h", addr));
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input memPeriphPkg::busWordT data);
        @(posedge Uart_send_trigger);
        cyc      <= 1'b1;
        stb      <= 1'b1;
        we       <= 1'b1;
        adr      <= addr;
        datWrite <= data;
        waitAck(addr);
        @(posedge Uart_send_trigger);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic busRead(input logic [31:0] addr, output memPeriphPkg::busWordT data);
        @(posedge Uart_send_trigger);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= addr;
        waitAck(addr);
        data = datRead;
        @(posedge Uart_send_trigger);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // Three decimal digits of n, hundreds in the top code
    function automatic memPeriphPkg::busWordT expectedDigits(input int n);
        int hundreds;
        int tens;
        int ones;
        hundreds = n / 100;
        tens     = (n / 10) % 10;
        ones     = n % 10;
        return {11'd0, memPeriphPkg::segTable[hundreds], memPeriphPkg::segTable[tens],
                memPeriphPkg::segTable[ones]};
    endfunction

    function automatic logic [31:0] ramAddr(input memPeriphPkg::wordIndexT idx);
        return memPeriphPkg::ramBase + {22'd0, idx, 2'b00};
    endfunction

    task automatic endTest(input string name);
        $display("[test] %s: %0d mismatches", name, errorCount - errorsAtStart);
        errorsAtStart = errorCount;
    endtask

    initial begin
        memPeriphPkg::busWordT   data;
        memPeriphPkg::busWordT   timerSetup;
        memPeriphPkg::wordIndexT idx;
        memPeriphPkg::wordIndexT addrList [64];
        memPeriphPkg::switchT    switchValue;
        int                      polls;
        logic                    flagSeen;

        seed          = 32'h44c3;
        errorCount    = 0;
        checkCount    = 0;
        errorsAtStart = 0;
        clk           = 1'b1;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        datWrite      = '0;
        switch        = '0;
        ledModel      = '0;
        tubeModel     = memPeriphPkg::tubeResetValue;
        for (int i = 0; i < memPeriphPkg::ramWords; i++) begin
            ramModel[i] = '0;
        end
        repeat (2) @(posedge Uart_send_trigger);
        clk <= 1'b0;

        busRead(memPeriphPkg::tubeAddr, data);
        compareWord("datRead tube", {14'd0, tubeModel}, data);
        compareTube("tube", tubeModel, tube);
        busRead(memPeriphPkg::ledAddr, data);
        compareWord("datRead led", '0, data);
        compareLed("led", '0, led);
        busRead(memPeriphPkg::ramBase, data);
        compareWord("datRead ram[0]", '0, data);
        endTest("reset values");

        for (int i = 0; i < 64; i++) begin
            idx         = memPeriphPkg::wordIndexT'($random(seed));
            addrList[i] = idx;
            data        = $random(seed);
            ramModel[idx] = data;
            busWrite(ramAddr(idx), data);
        end
        for (int i = 0; i < 64; i++) begin
            busRead(ramAddr(addrList[i]), data);
            compareWord($sformatf("datRead ram[%0d]", addrList[i]), ramModel[addrList[i]], data);
        end
        endTest("random RAM");

        for (int i = 0; i < 32; i++) begin
            idx = memPeriphPkg::wordIndexT'($random(seed));
            busRead(memPeriphPkg::digitBase + {22'd0, idx, 2'b00}, data);
            compareWord($sformatf("datRead digit[%0d]", idx), expectedDigits(idx), data);
        end
        // The table is read only
        busWrite(memPeriphPkg::digitBase + {22'd0, idx, 2'b00}, $random(seed));
        busRead(memPeriphPkg::digitBase + {22'd0, idx, 2'b00}, data);
        compareWord("datRead digit after write", expectedDigits(idx), data);
        endTest("digit table");

        for (int i = 0; i < 8; i++) begin
            data     = $random(seed);
            ledModel = data[7:0];
            busWrite(memPeriphPkg::ledAddr, data);
            // The register updates on the edge after the strobe
            @(negedge Uart_send_trigger);
            compareLed("led", ledModel, led);
            busRead(memPeriphPkg::ledAddr, data);
            compareWord("datRead led", {24'd0, ledModel}, data);
            data      = $random(seed);
            tubeModel = data[17:0];
            busWrite(memPeriphPkg::tubeAddr, data);
            @(negedge Uart_send_trigger);
            compareTube("tube", tubeModel, tube);
            busRead(memPeriphPkg::tubeAddr, data);
            compareWord("datRead tube", {14'd0, tubeModel}, data);
            switchValue = memPeriphPkg::switchT'($random(seed));
            @(posedge Uart_send_trigger);
            switch <= switchValue;
            busRead(memPeriphPkg::switchAddr, data);
            compareWord("datRead switch", {24'd0, switchValue}, data);
        end
        endTest("LED, tube and switch");

        timerSetup = '0;
        timerSetup[memPeriphPkg::timerEnableBit]    = 1'b1;
        timerSetup[memPeriphPkg::timerIrqEnableBit] = 1'b1;
        busWrite(memPeriphPkg::timerReloadAddr, 32'hFFFF_FFF0);
        busRead(memPeriphPkg::timerReloadAddr, data);
        compareWord("datRead reload", 32'hFFFF_FFF0, data);
        busWrite(memPeriphPkg::timerCountAddr, 32'hFFFF_FFF0);
        busWrite(memPeriphPkg::timerControlAddr, timerSetup);
        polls    = 0;
        flagSeen = 1'b0;
        while (!flagSeen && polls < pollLimit) begin
            busRead(memPeriphPkg::timerControlAddr, data);
            flagSeen = data[memPeriphPkg::timerFlagBit];
            polls++;
        end
        if (!flagSeen) begin
            abortRun("Timer flag never set while polling control");
        end
        compareBit("timerExpired", 1'b1, timerExpired);
        // Keep irq enabled so only the flag clear can drop timerExpired
        timerSetup[memPeriphPkg::timerEnableBit] = 1'b0;
        busWrite(memPeriphPkg::timerControlAddr, timerSetup);
        busRead(memPeriphPkg::timerControlAddr, data);
        compareWord("datRead control", timerSetup, data);
        compareBit("timerExpired", 1'b0, timerExpired);
        endTest("interval timer");

        busRead(32'h4000_0018, data);
        compareWord("datRead unmapped", '0, data);
        busRead(32'h0000_0800, data);
        compareWord("datRead unmapped", '0, data);
        endTest("unmapped addresses");

        errorCount += uut.busController.busCheck.violations;
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dataMemory.f */
rtl/memPeriphPkg.sv
rtl/periphBusIf.sv
rtl/digitDecoder.sv
rtl/dataRam.sv
rtl/ioPorts.sv
rtl/intervalTimer.sv
rtl/busController.sv
rtl/dataMemory.sv
verif/dataMemoryAssert.sv
verif/dataMemoryTb.sv

/* Makefile */
SIM      = verilator
TOP      = dataMemoryTb
FILELIST = dataMemory.f
BUILDDIR = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILDDIR)
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
